/* include/pipe_config.svh */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// one control bit per pipeline register plus PC and WB
`define PIPE_STAGES 6

// cycles EX stays occupied by a mul or div
`define MULDIV_CYCLES 4

`endif

/* rtl/hazard_detect.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module hazard_detect (
  input  wire                 clk,
  input  wire                 rst,
  input  wire isa_pkg::instr_u     id_instr_i,
  input  wire                 muldiv_start_i,
  input  wire pipe_pkg::ctrl_vec_t stall_i,
  input  wire pipe_pkg::ctrl_vec_t flush_i,
  output logic                load_use_o,
  output logic                mul_div_busy_o
);

  localparam int CNT_W = $clog2(`MULDIV_CYCLES + 1);

  logic [6:0]       id_opc;
  logic             rs1_used;
  logic             rs2_used;
  logic             ex_is_load;  // load sitting in ID/EX
  logic [4:0]       ex_rd;
  logic [CNT_W-1:0] muldiv_cnt;  // remaining busy cycles after the start cycle
  logic             muldiv_go;

  assign id_opc = id_instr_i.r_fmt.opcode;

  // which source fields the ID instruction really reads
  assign rs1_used = id_opc inside {isa_pkg::OPC_LOAD, isa_pkg::OPC_OP_IMM, isa_pkg::OPC_STORE,
                                   isa_pkg::OPC_OP, isa_pkg::OPC_BRANCH};
  assign rs2_used = id_opc inside {isa_pkg::OPC_STORE, isa_pkg::OPC_OP, isa_pkg::OPC_BRANCH};

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_is_load <= 1'b0;
    end else if (flush_i[pipe_pkg::STG_ID_EX]) begin
      ex_is_load <= 1'b0;  // bubble into EX
    end else if (!stall_i[pipe_pkg::STG_ID_EX]) begin
      ex_is_load <= (id_opc == isa_pkg::OPC_LOAD);
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[pipe_pkg::STG_ID_EX] && !flush_i[pipe_pkg::STG_ID_EX]) begin
      ex_rd <= id_instr_i.i_fmt.rd;
    end
  end

  // x0 never creates a dependency
  assign load_use_o = ex_is_load && (ex_rd != 5'd0) &&
                      ((rs1_used && (id_instr_i.r_fmt.rs1 == ex_rd)) ||
                       (rs2_used && (id_instr_i.r_fmt.rs2 == ex_rd)));

  // start only accepted while idle
  assign muldiv_go = muldiv_start_i && (muldiv_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      muldiv_cnt <= '0;
    end else if (muldiv_go) begin
      muldiv_cnt <= CNT_W'(`MULDIV_CYCLES - 1);  // start cycle counts as the first
    end else if (muldiv_cnt != '0) begin
      muldiv_cnt <= muldiv_cnt - CNT_W'(1);
    end
  end

  assign mul_div_busy_o = muldiv_go || (muldiv_cnt != '0);

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    muldiv_cnt <= CNT_W'(`MULDIV_CYCLES))
    else $error("mul/div counter out of range: %0d", muldiv_cnt);

endmodule

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // one instruction word, decoded as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;  // rs2 field lives in here for I-type
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } instr_u;

  // major opcodes relevant to hazard detection
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* rtl/pipe_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire isa_pkg::instr_u     id_instr_i,
  input  wire                 muldiv_start_i,
  input  wire                 if_rdata_valid_i,
  input  wire                 ram_stall_if_i,
  input  wire                 ram_stall_mem_i,
  input  wire                 trap_stall_i,
  input  wire                 trap_flush_i,
  input  wire                 jump_i,
  output pipe_pkg::ctrl_vec_t stall_o,
  output pipe_pkg::ctrl_vec_t flush_o,
  output pipe_pkg::ctrl_vec_t stage_valid_o
);

  logic load_use;
  logic mul_div_busy;

  hazard_detect u_hazard_detect (
    .clk            (clk),
    .rst            (rst),
    .id_instr_i     (id_instr_i),
    .muldiv_start_i (muldiv_start_i),
    .stall_i        (stall_o),  // vectors fed back to hold the ID/EX load
    .flush_i        (flush_o),
    .load_use_o     (load_use),
    .mul_div_busy_o (mul_div_busy)
  );

  pipeline_control u_pipeline_control (
    .rst              (rst),
    .if_rdata_valid_i (if_rdata_valid_i),
    .ram_stall_if_i   (ram_stall_if_i),
    .ram_stall_mem_i  (ram_stall_mem_i),
    .trap_stall_i     (trap_stall_i),
    .trap_flush_i     (trap_flush_i),
    .jump_i           (jump_i),
    .mul_div_busy_i   (mul_div_busy),
    .load_use_i       (load_use),
    .stall_o          (stall_o),
    .flush_o          (flush_o)
  );

  stage_valid_tracker u_stage_valid_tracker (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_o),
    .flush_i       (flush_o),
    .stage_valid_o (stage_valid_o)
  );

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
`default_nettype none

`include "pipe_config.svh"

package pipe_pkg;

  // stall/flush word, one bit per stage register
  typedef logic [`PIPE_STAGES-1:0] ctrl_vec_t;

  // bit positions inside ctrl_vec_t
  localparam int STG_PC    = 0;
  localparam int STG_IF_ID = 1;
  localparam int STG_ID_EX = 2;
  localparam int STG_EX_MEM = 3;
  localparam int STG_MEM_WB = 4;
  localparam int STG_WB    = 5;

endpackage

`default_nettype wire

/* rtl/pipeline_control.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeline_control (
  input  wire  rst,
  input  wire  if_rdata_valid_i,
  input  wire  ram_stall_if_i,
  input  wire  ram_stall_mem_i,
  input  wire  trap_stall_i,
  input  wire  trap_flush_i,
  input  wire  jump_i,
  input  wire  mul_div_busy_i,
  input  wire  load_use_i,
  output pipe_pkg::ctrl_vec_t stall_o,
  output pipe_pkg::ctrl_vec_t flush_o
);

  // single-bubble flushes, named by the register that gets the bubble
  localparam pipe_pkg::ctrl_vec_t RAM_MEM_FLUSH  = pipe_pkg::ctrl_vec_t'(1) << pipe_pkg::STG_MEM_WB;
  localparam pipe_pkg::ctrl_vec_t MULDIV_FLUSH   = pipe_pkg::ctrl_vec_t'(1) << pipe_pkg::STG_EX_MEM;
  localparam pipe_pkg::ctrl_vec_t LOAD_USE_FLUSH = pipe_pkg::ctrl_vec_t'(1) << pipe_pkg::STG_ID_EX;

  localparam pipe_pkg::ctrl_vec_t RAM_STALL     = 6'b001111;  // PC up to EX/MEM
  localparam pipe_pkg::ctrl_vec_t TRAP_FLUSH    = 6'b001110;
  localparam pipe_pkg::ctrl_vec_t TRAP_F_STALL  = 6'b000010;
  localparam pipe_pkg::ctrl_vec_t TRAP_S_STALL  = 6'b111111;
  localparam pipe_pkg::ctrl_vec_t JUMP_STALL    = 6'b000010;
  localparam pipe_pkg::ctrl_vec_t JUMP_FLUSH    = 6'b000110;
  localparam pipe_pkg::ctrl_vec_t MULDIV_STALL  = 6'b000111;
  localparam pipe_pkg::ctrl_vec_t FRONT_STALL   = 6'b000011;  // PC and IF/ID only
  localparam pipe_pkg::ctrl_vec_t RESET_FLUSH   = 6'b011111;

  logic load_use_only;

  // later stages win
  always_comb begin
    stall_o = '0;
    flush_o = '0;
    if (rst) begin
      flush_o = RESET_FLUSH;
    end else if (ram_stall_mem_i) begin
      stall_o = RAM_STALL;
      flush_o = RAM_MEM_FLUSH;
    end else if (ram_stall_if_i) begin
      stall_o = RAM_STALL;  // no flush, fetch just waits
    end else if (trap_flush_i) begin
      stall_o = TRAP_F_STALL;
      flush_o = TRAP_FLUSH;
    end else if (trap_stall_i) begin
      stall_o = TRAP_S_STALL;
      flush_o = TRAP_FLUSH;
    end else if (jump_i) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (mul_div_busy_i) begin
      stall_o = MULDIV_STALL;
      flush_o = MULDIV_FLUSH;
    end else if (load_use_i) begin
      stall_o = FRONT_STALL;
      flush_o = LOAD_USE_FLUSH;
    end else if (!if_rdata_valid_i) begin
      stall_o = FRONT_STALL;
    end
  end

  assign load_use_only = !rst && load_use_i && !ram_stall_mem_i && !ram_stall_if_i &&
                         !trap_flush_i && !trap_stall_i && !jump_i && !mul_div_busy_i;

  // load-use from hazard_detect must freeze only the front end
  always_comb begin
    if (load_use_only) begin
      a_load_use_stall: assert (stall_o == FRONT_STALL)
        else $error("load-use stall vector wrong: %b", stall_o);
    end
  end

endmodule

`default_nettype wire

/* rtl/stage_valid_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_valid_tracker (
  input  wire                 clk,
  input  wire                 rst,
  input  wire pipe_pkg::ctrl_vec_t stall_i,
  input  wire pipe_pkg::ctrl_vec_t flush_i,
  output pipe_pkg::ctrl_vec_t stage_valid_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid_o <= '0;
    end else begin
      // PC always has a next instruction to fetch
      if (flush_i[pipe_pkg::STG_PC]) begin
        stage_valid_o[pipe_pkg::STG_PC] <= 1'b0;
      end else if (!stall_i[pipe_pkg::STG_PC]) begin
        stage_valid_o[pipe_pkg::STG_PC] <= 1'b1;
      end

      for (int i = pipe_pkg::STG_IF_ID; i <= pipe_pkg::STG_WB; i++) begin
        if (flush_i[i]) begin
          stage_valid_o[i] <= 1'b0;  // flush beats stall
        end else if (!stall_i[i]) begin
          stage_valid_o[i] <= stage_valid_o[i-1];
        end
      end
    end
  end

  // whatever was flushed must read invalid one cycle later
  a_flush_clears: assert property (@(posedge clk) disable iff (rst)
    (flush_i != '0) |=> ((stage_valid_o & $past(flush_i)) == '0))
    else $error("flushed stage still valid: %b", stage_valid_o);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module tb_pipe_ctrl \
  -Mdir obj_dir -o vsim -f src.f > sim.log 2>&1 &&
  ./obj_dir/vsim >> sim.log 2>&1
grep -q "^Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* src.f */
+incdir+include
rtl/pipe_pkg.sv
rtl/isa_pkg.sv
rtl/hazard_detect.sv
rtl/pipeline_control.sv
rtl/stage_valid_tracker.sv
rtl/pipe_ctrl_top.sv
verif/clk_gen.sv
verif/tb_pipe_ctrl.sv

/* verif/clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release reset just after the last reset edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verif/pipe_ctrl_stim.txt */
# start fetch_valid ram_if ram_mem trap_stall trap_flush jump instr(hex) | expected
# expected: stall flush stage_valid, each written WB..PC
0 1 0 0 0 0 0 00000013 000000 011111 000000  # reset
0 1 0 0 0 0 1 00000013 000000 011111 000000  # jump masked by reset
0 1 0 0 0 0 0 00000013 000000 000000 000000  # reset released
0 1 0 0 0 0 0 00000013 000000 000000 000001  # valid fills from PC
0 1 0 0 0 0 0 00000013 000000 000000 000011
0 1 0 0 0 0 0 00000013 000000 000000 000111
0 1 0 0 0 0 0 00000013 000000 000000 001111
0 1 0 0 0 0 0 00000013 000000 000000 011111
0 1 0 0 0 0 0 00000013 000000 000000 111111
0 1 0 0 0 0 0 0000a283 000000 000000 111111  # lw x5
0 1 0 0 0 0 0 00728333 000011 000100 111111  # add reads x5 via rs1
0 1 0 0 0 0 0 00728333 000000 000000 111011
0 1 0 0 0 0 0 0000a283 000000 000000 110111  # lw x5
0 1 0 0 0 0 0 00538333 000011 000100 101111  # add reads x5 via rs2
0 1 0 0 0 0 0 00538333 000000 000000 011011
0 1 0 0 0 0 0 0000a283 000000 000000 110111  # lw x5
0 1 0 0 0 0 0 00538313 000000 000000 101111  # addi, imm bits match rd
0 1 0 0 0 0 0 0000a003 000000 000000 011111  # lw x0
0 1 0 0 0 0 0 00700333 000000 000000 111111  # add reads x0
1 1 0 0 0 0 0 00000013 000111 001000 111111  # mul/div start
0 1 0 0 0 0 0 00000013 000111 001000 110111
1 1 0 0 0 0 0 00000013 000111 001000 100111  # second start ignored
0 1 0 0 0 0 0 00000013 000111 001000 000111
0 1 0 0 0 0 0 00000013 000000 000000 000111  # busy over
0 1 0 0 0 0 0 00000013 000000 000000 001111
0 1 0 0 0 0 0 00000013 000000 000000 011111
0 1 0 0 0 0 0 00000013 000000 000000 111111
0 0 1 1 0 1 1 00000013 001111 010000 111111  # ram mem wins
0 0 1 0 1 1 1 00000013 001111 000000 101111  # ram if wins
0 0 0 0 1 1 1 00000013 000010 001110 011111  # trap flush wins
0 0 0 0 1 0 1 00000013 111111 001110 110001  # trap stall wins
0 0 0 0 0 0 1 00000013 000010 000110 110001  # jump
0 0 0 0 0 0 0 00000013 000011 000000 100001  # fetch not valid
0 1 0 0 0 0 0 0000a283 000000 000000 000001  # lw x5
1 0 0 0 0 0 0 00728333 000111 001000 000011  # mul/div over load-use
0 0 0 0 0 0 0 00728333 000111 001000 000011
0 0 0 0 0 0 0 00728333 000111 001000 000011
0 0 0 0 0 0 0 00728333 000111 001000 000011
0 0 0 0 0 0 0 00728333 000011 000100 000011  # load-use over fetch
0 0 0 0 0 0 0 00728333 000011 000000 000011  # fetch not valid
0 1 0 0 0 0 0 00000013 000000 000000 000111
0 1 0 0 0 0 0 00000013 000000 000000 001111

/* verif/tb_pipe_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_ctrl;

  localparam int    CLK_PERIOD = 10;
  localparam int    DRIVE_DLY  = 1;  // ns after the rising edge
  localparam string STIM_FILE  = "verif/pipe_ctrl_stim.txt";

  logic                clk;
  logic                rst;
  isa_pkg::instr_u     id_instr;
  logic                muldiv_start;
  logic                if_rdata_valid;
  logic                ram_stall_if;
  logic                ram_stall_mem;
  logic                trap_stall;
  logic                trap_flush;
  logic                jump;
  pipe_pkg::ctrl_vec_t stall;
  pipe_pkg::ctrl_vec_t flush;
  pipe_pkg::ctrl_vec_t stage_valid;

  // request bits, packed in stim column order
  logic [6:0]          req_q[$];
  logic [31:0]         instr_q[$];
  pipe_pkg::ctrl_vec_t exp_stall_q[$];
  pipe_pkg::ctrl_vec_t exp_flush_q[$];
  pipe_pkg::ctrl_vec_t exp_valid_q[$];
  int                  vec_cnt;
  int                  cur_vec;
  bit                  stim_loaded;

  clk_gen #(
    .PERIOD_NS  (CLK_PERIOD),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  pipe_ctrl_top dut (
    .clk              (clk),
    .rst              (rst),
    .id_instr_i       (id_instr),
    .muldiv_start_i   (muldiv_start),
    .if_rdata_valid_i (if_rdata_valid),
    .ram_stall_if_i   (ram_stall_if),
    .ram_stall_mem_i  (ram_stall_mem),
    .trap_stall_i     (trap_stall),
    .trap_flush_i     (trap_flush),
    .jump_i           (jump),
    .stall_o          (stall),
    .flush_o          (flush),
    .stage_valid_o    (stage_valid)
  );

  task automatic read_stim();
    int                  fd;
    string               line;
    logic                s_start;
    logic                s_fetch;
    logic                s_ram_if;
    logic                s_ram_mem;
    logic                s_trap_stall;
    logic                s_trap_flush;
    logic                s_jump;
    logic [31:0]         s_instr;
    pipe_pkg::ctrl_vec_t s_stall;
    pipe_pkg::ctrl_vec_t s_flush;
    pipe_pkg::ctrl_vec_t s_valid;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      $display("Done: errors found");
      $fatal(1, "stimulus file missing");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          // comment and blank lines give fewer than 11 fields
          if ($sscanf(line, "%b %b %b %b %b %b %b %h %b %b %b", s_start, s_fetch,
                      s_ram_if, s_ram_mem, s_trap_stall, s_trap_flush, s_jump,
                      s_instr, s_stall, s_flush, s_valid) == 11) begin
            req_q.push_back({s_start, s_fetch, s_ram_if, s_ram_mem,
                             s_trap_stall, s_trap_flush, s_jump});
            instr_q.push_back(s_instr);
            exp_stall_q.push_back(s_stall);
            exp_flush_q.push_back(s_flush);
            exp_valid_q.push_back(s_valid);
          end
        end
      end
      $fclose(fd);
      if (instr_q.size() == 0) begin
        $display("the stimulus file %s holds no vectors", STIM_FILE);
        $display("Done: errors found");
        $fatal(1, "empty stimulus");
      end
    end
  endtask

  task automatic apply_vector(input int idx);
    {muldiv_start, if_rdata_valid, ram_stall_if, ram_stall_mem,
     trap_stall, trap_flush, jump} = req_q[idx];
    id_instr = instr_q[idx];
  endtask

  task automatic check_val(input string name, input pipe_pkg::ctrl_vec_t actual,
                           input pipe_pkg::ctrl_vec_t expected);
    if (actual !== expected) begin
      $display("[ERROR] t=%0d ns vec %0d %s: got %b expected %b",
               $time, cur_vec, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    id_instr       = '0;
    muldiv_start   = 1'b0;
    if_rdata_valid = 1'b1;
    ram_stall_if   = 1'b0;
    ram_stall_mem  = 1'b0;
    trap_stall     = 1'b0;
    trap_flush     = 1'b0;
    jump           = 1'b0;
    cur_vec        = 0;
    read_stim();
    vec_cnt     = instr_q.size();
    stim_loaded = 1'b1;
    for (int i = 0; i < vec_cnt; i++) begin
      @(posedge clk);
      #(DRIVE_DLY);
      cur_vec = i;
      apply_vector(i);
      #(CLK_PERIOD - DRIVE_DLY - 1);  // 1 ns before the next edge
      check_val("stall_o", stall, exp_stall_q[i]);
      check_val("flush_o", flush, exp_flush_q[i]);
      check_val("stage_valid_o", stage_valid, exp_valid_q[i]);
    end
    $display("Done: no errors");
    $finish;
  end

  // vector count plus some slack
  initial begin : watchdog
    wait (stim_loaded);
    #((vec_cnt + 20) * CLK_PERIOD);
    $display("timeout: the stimulus never finished within %0d cycles", vec_cnt + 20);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
